// File: logic/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Word and register file geometry
`define MIPS_DATA_W     32
`define MIPS_REG_COUNT  32

// First fetch after reset, and the store address that ends a run
`define MIPS_RESET_PC   32'h0040_0000
`define MIPS_HALT_ADDR  32'h1001_0ffc

// ALU request coming out of the control word
`define MIPS_ALUOP_ADD   2'd0
`define MIPS_ALUOP_SUB   2'd1
`define MIPS_ALUOP_FUNCT 2'd2

// Second ALU operand select
`define MIPS_SRCB_REG    3'd0
`define MIPS_SRCB_FOUR   3'd1
`define MIPS_SRCB_IMM    3'd2
`define MIPS_SRCB_IMM_SH 3'd3
`define MIPS_SRCB_SHAMT  3'd4

// Next PC select
`define MIPS_PCSRC_ALU    2'd0
`define MIPS_PCSRC_ALUOUT 2'd1
`define MIPS_PCSRC_JUMP   2'd2

`endif

// File: logic/mips_pkg.sv
package mips_pkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_addi  = 6'h08,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_exec,
		st_mem,
		st_wb,
		st_brj
	} ctrl_state_e;

	// One control word per FSM state
	typedef struct packed {
		logic       ir_write;
		logic       pc_write;
		logic       pc_write_cond;
		logic       iord;
		logic       reg_dst;
		logic       mem_to_reg;
		logic       reg_write;
		logic       alu_src_a;
		logic [2:0] alu_src_b;
		logic [1:0] alu_op;
		logic [1:0] pc_source;
	} ctrl_word_t;

endpackage

// File: logic/mips_ctrl_if.sv
`timescale 1ns/10ps

interface mips_ctrl_if;
	import mips_pkg::*;

	// Control to datapath
	ctrl_word_t ctrl;

	// Decode fields and compare result back to the FSM
	opcode_e    op;
	funct_e     funct;
	logic       zero;

	modport control (
		output ctrl,
		input  op,
		input  funct,
		input  zero
	);

	modport datapath (
		input  ctrl,
		output op,
		output funct,
		output zero
	);

endinterface

// File: logic/mips_control.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_control (
	input  logic         clk,
	input  logic         rst_n,
	mips_ctrl_if.control ctrl,
	output logic         mem_req,
	output logic         mem_we,
	input  logic         mem_done
);
	import mips_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	ctrl_word_t  cw;

	assign ctrl.ctrl = cw;

	//////////////////////////////////////////////////
	// State sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_fetch;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			st_fetch: begin
				if (mem_done) state_nxt = st_decode;
			end
			st_decode: begin
				unique case (ctrl.op)
					op_rtype, op_addi, op_lw, op_sw: state_nxt = st_exec;
					op_beq, op_j: state_nxt = st_brj;
					// Unsupported opcode, skip it
					default: state_nxt = st_fetch;
				endcase
			end
			st_exec: begin
				if (ctrl.op == op_lw || ctrl.op == op_sw) state_nxt = st_mem;
				else state_nxt = st_wb;
			end
			st_mem: begin
				if (mem_done) state_nxt = (ctrl.op == op_lw) ? st_wb : st_fetch;
			end
			st_wb: state_nxt = st_fetch;
			st_brj: state_nxt = st_fetch;
			default: state_nxt = st_fetch;
		endcase
	end

	//////////////////////////////////////////////////
	// Control word per state
	//////////////////////////////////////////////////

	always_comb begin
		cw = '0;
		mem_req = 1'b0;
		mem_we = 1'b0;
		unique case (state)
			st_fetch: begin
				// PC+4 goes back into PC as the word arrives
				mem_req = 1'b1;
				cw.alu_src_b = `MIPS_SRCB_FOUR;
				cw.ir_write = mem_done;
				cw.pc_write = mem_done;
			end
			st_decode: begin
				// Branch target lands in ALUOut
				cw.alu_src_b = `MIPS_SRCB_IMM_SH;
			end
			st_exec: begin
				cw.alu_src_a = 1'b1;
				if (ctrl.op == op_rtype) begin
					cw.alu_op = `MIPS_ALUOP_FUNCT;
					cw.alu_src_b = (ctrl.funct == fn_sll) ? `MIPS_SRCB_SHAMT : `MIPS_SRCB_REG;
				end else begin
					cw.alu_src_b = `MIPS_SRCB_IMM;
				end
			end
			st_mem: begin
				// Keep the address computation so ALUOut holds still
				mem_req = 1'b1;
				mem_we = (ctrl.op == op_sw);
				cw.iord = 1'b1;
				cw.alu_src_a = 1'b1;
				cw.alu_src_b = `MIPS_SRCB_IMM;
			end
			st_wb: begin
				cw.reg_write = 1'b1;
				cw.reg_dst = (ctrl.op == op_rtype);
				cw.mem_to_reg = (ctrl.op == op_lw);
			end
			st_brj: begin
				cw.alu_src_a = 1'b1;
				cw.alu_op = `MIPS_ALUOP_SUB;
				if (ctrl.op == op_j) begin
					cw.pc_write = 1'b1;
					cw.pc_source = `MIPS_PCSRC_JUMP;
				end else begin
					cw.pc_write_cond = 1'b1;
					cw.pc_source = `MIPS_PCSRC_ALUOUT;
				end
			end
			default: cw = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_done |=> mem_req)
		else $error("mem_req dropped before mem_done");

	ir_reg_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
		!(cw.ir_write && cw.reg_write))
		else $error("ir_write and reg_write both high");

	known_op_a: assert property (@(posedge clk) disable iff (!rst_n)
		state == st_decode |-> ctrl.op inside {op_rtype, op_addi, op_lw, op_sw, op_beq, op_j})
		else $error("unknown opcode %h", ctrl.op);

	// Compare operands must come from written registers
	zero_known_a: assert property (@(posedge clk) disable iff (!rst_n)
		state == st_brj |-> !$isunknown(ctrl.zero))
		else $error("branch compare on undefined operands");

endmodule

// File: logic/mips_datapath.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_datapath (
	input  logic                    clk,
	input  logic                    rst_n,
	mips_ctrl_if.datapath           ctrl,
	input  logic                    mem_done,
	input  logic [`MIPS_DATA_W-1:0] mem_rdata,
	output logic [`MIPS_DATA_W-1:0] mem_addr,
	output logic [`MIPS_DATA_W-1:0] mem_wdata
);
	import mips_pkg::*;

	localparam int REG_AW = $clog2(`MIPS_REG_COUNT);

	logic [`MIPS_DATA_W-1:0] pc_q;
	logic [`MIPS_DATA_W-1:0] ir_q;
	logic [`MIPS_DATA_W-1:0] mdr_q;
	logic [`MIPS_DATA_W-1:0] a_q;
	logic [`MIPS_DATA_W-1:0] b_q;
	logic [`MIPS_DATA_W-1:0] alu_out_q;
	logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

	logic [REG_AW-1:0]       rs;
	logic [REG_AW-1:0]       rt;
	logic [REG_AW-1:0]       rd;
	logic [REG_AW-1:0]       wr_addr;
	logic [`MIPS_DATA_W-1:0] rd_data1;
	logic [`MIPS_DATA_W-1:0] rd_data2;
	logic [`MIPS_DATA_W-1:0] wr_data;
	logic [`MIPS_DATA_W-1:0] imm_ext;
	logic [`MIPS_DATA_W-1:0] imm_sh;
	logic [`MIPS_DATA_W-1:0] shamt_ext;
	logic [`MIPS_DATA_W-1:0] jump_addr;
	logic [`MIPS_DATA_W-1:0] alu_a;
	logic [`MIPS_DATA_W-1:0] alu_b;
	logic [`MIPS_DATA_W-1:0] alu_y;
	logic [`MIPS_DATA_W-1:0] pc_next;
	logic                    alu_zero;
	logic                    pc_en;
	funct_e                  fn;
	alu_op_e                 alu_fn;

	//////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////

	assign rs = ir_q[25:21];
	assign rt = ir_q[20:16];
	assign rd = ir_q[15:11];
	assign fn = funct_e'(ir_q[5:0]);

	assign ctrl.op = opcode_e'(ir_q[31:26]);
	assign ctrl.funct = fn;

	assign imm_ext = {{(`MIPS_DATA_W-16){ir_q[15]}}, ir_q[15:0]};
	assign imm_sh = {imm_ext[`MIPS_DATA_W-3:0], 2'b00};
	assign shamt_ext = {{(`MIPS_DATA_W-5){1'b0}}, ir_q[10:6]};
	// PC already points past the jump here
	assign jump_addr = {pc_q[31:28], ir_q[25:0], 2'b00};

	//////////////////////////////////////////////////
	// Architectural and staging registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= `MIPS_RESET_PC;
		end else if (pc_en) begin
			pc_q <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.ctrl.ir_write) ir_q <= mem_rdata;
		if (mem_done && ctrl.ctrl.iord) mdr_q <= mem_rdata;
		a_q <= rd_data1;
		b_q <= rd_data2;
		alu_out_q <= alu_y;
	end

	// Register file, r0 never written and reads as zero
	assign wr_addr = ctrl.ctrl.reg_dst ? rd : rt;
	assign wr_data = ctrl.ctrl.mem_to_reg ? mdr_q : alu_out_q;

	always_ff @(posedge clk) begin
		if (ctrl.ctrl.reg_write && wr_addr != '0) regs[wr_addr] <= wr_data;
	end

	assign rd_data1 = (rs == '0) ? '0 : regs[rs];
	assign rd_data2 = (rt == '0) ? '0 : regs[rt];

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	assign alu_a = ctrl.ctrl.alu_src_a ? a_q : pc_q;

	always_comb begin
		unique case (ctrl.ctrl.alu_src_b)
			`MIPS_SRCB_REG:    alu_b = b_q;
			`MIPS_SRCB_FOUR:   alu_b = `MIPS_DATA_W'(4);
			`MIPS_SRCB_IMM:    alu_b = imm_ext;
			`MIPS_SRCB_IMM_SH: alu_b = imm_sh;
			`MIPS_SRCB_SHAMT:  alu_b = shamt_ext;
			default:           alu_b = b_q;
		endcase
	end

	always_comb begin
		alu_fn = alu_add;
		if (ctrl.ctrl.alu_op == `MIPS_ALUOP_SUB) begin
			alu_fn = alu_sub;
		end else if (ctrl.ctrl.alu_op == `MIPS_ALUOP_FUNCT) begin
			unique case (fn)
				fn_sub:  alu_fn = alu_sub;
				fn_and:  alu_fn = alu_and;
				fn_or:   alu_fn = alu_or;
				fn_slt:  alu_fn = alu_slt;
				fn_sll:  alu_fn = alu_sll;
				default: alu_fn = alu_add;
			endcase
		end
	end

	always_comb begin
		unique case (alu_fn)
			alu_sub: alu_y = alu_a - alu_b;
			alu_and: alu_y = alu_a & alu_b;
			alu_or:  alu_y = alu_a | alu_b;
			alu_slt: alu_y = {{(`MIPS_DATA_W-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
			// sll shifts rt, which sits in B, by the shamt operand
			alu_sll: alu_y = b_q << alu_b[4:0];
			default: alu_y = alu_a + alu_b;
		endcase
	end

	assign alu_zero = (alu_y == '0);
	assign ctrl.zero = alu_zero;

	// Next PC
	always_comb begin
		unique case (ctrl.ctrl.pc_source)
			`MIPS_PCSRC_ALUOUT: pc_next = alu_out_q;
			`MIPS_PCSRC_JUMP:   pc_next = jump_addr;
			default:            pc_next = alu_y;
		endcase
	end

	assign pc_en = ctrl.ctrl.pc_write | (ctrl.ctrl.pc_write_cond & alu_zero);

	assign mem_addr = ctrl.ctrl.iord ? alu_out_q : pc_q;
	assign mem_wdata = b_q;

endmodule

// File: logic/mips_bus_master.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_bus_master (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      mem_req,
	input  logic                      mem_we,
	input  logic [`MIPS_DATA_W-1:0]   mem_addr,
	input  logic [`MIPS_DATA_W-1:0]   mem_wdata,
	output logic                      mem_done,
	output logic [`MIPS_DATA_W-1:0]   mem_rdata,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [`MIPS_DATA_W-1:0]   wb_adr,
	output logic [`MIPS_DATA_W-1:0]   wb_dat_w,
	output logic [`MIPS_DATA_W/8-1:0] wb_sel,
	input  logic [`MIPS_DATA_W-1:0]   wb_dat_r,
	input  logic                      wb_ack
);

	// Cycle opens on a request while idle and closes on ack
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else if (wb_cyc) begin
			if (wb_ack) begin
				wb_cyc <= 1'b0;
				wb_stb <= 1'b0;
				wb_we <= 1'b0;
			end
		end else if (mem_req) begin
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_we <= mem_we;
		end
	end

	// Address and data only load as a cycle opens
	always_ff @(posedge clk) begin
		if (!wb_cyc && mem_req) begin
			wb_adr <= mem_addr;
			wb_dat_w <= mem_wdata;
		end
	end

	assign wb_sel = '1;
	assign mem_done = wb_cyc & wb_ack;
	assign mem_rdata = wb_dat_r;

	stable_a: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else $error("Wishbone request changed before ack");

	stb_cyc_a: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc)
		else $error("stb high without cyc");

endmodule

// File: logic/mips_core.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_core (
	input  logic                      clk,
	input  logic                      rst_n,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [`MIPS_DATA_W-1:0]   wb_adr,
	output logic [`MIPS_DATA_W-1:0]   wb_dat_w,
	output logic [`MIPS_DATA_W/8-1:0] wb_sel,
	input  logic [`MIPS_DATA_W-1:0]   wb_dat_r,
	input  logic                      wb_ack
);

	logic                    mem_req;
	logic                    mem_we;
	logic                    mem_done;
	logic [`MIPS_DATA_W-1:0] mem_addr;
	logic [`MIPS_DATA_W-1:0] mem_wdata;
	logic [`MIPS_DATA_W-1:0] mem_rdata;

	mips_ctrl_if ctrl_if ();

	mips_control control_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl_if),
		.mem_req  (mem_req),
		.mem_we   (mem_we),
		.mem_done (mem_done)
	);

	mips_datapath datapath_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl_if),
		.mem_done  (mem_done),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	// Fetch and data accesses share the one bus
	mips_bus_master bus_master_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_done  (mem_done),
		.mem_rdata (mem_rdata),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_sel    (wb_sel),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack)
	);

endmodule

// File: verification/mips_checker.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_checker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [31:0] wb_adr,
	input  logic [31:0] wb_dat_w,
	input  logic [3:0]  wb_sel,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack,
	output int          errors,
	output int          checks,
	output int          retired,
	output logic        halted
);

	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] ref_regs [32];
	logic [31:0] ref_pc;
	logic        exp_data;
	logic        exp_we;
	logic [31:0] exp_adr;
	logic [31:0] exp_dat;
	logic [4:0]  exp_rt;

	logic        in_reset = 1'b0;
	logic        prev_valid = 1'b0;
	logic        prev_stb;
	logic        prev_ack;
	logic        prev_we;
	logic [31:0] prev_adr;
	logic [31:0] prev_dat_w;

	initial begin
		errors = 0;
		checks = 0;
		retired = 0;
		halted = 1'b0;
	end

	function automatic void preload(input logic [31:0] addr, input logic [31:0] word);
		ref_mem[addr] = word;
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		if (ref_mem.exists(addr)) return ref_mem[addr];
		return '0;
	endfunction

	function automatic logic [31:0] reg_value(input logic [4:0] r);
		return (r == 5'd0) ? 32'd0 : ref_regs[r];
	endfunction

	function automatic void reg_update(input logic [4:0] r, input logic [31:0] v);
		if (r != 5'd0) ref_regs[r] = v;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// ISA reference, one instruction per call
	//////////////////////////////////////////////////

	function automatic void ref_step(input logic [31:0] instr);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] pc4;
		op = instr[31:26];
		fn = instr[5:0];
		a = reg_value(instr[25:21]);
		b = reg_value(instr[20:16]);
		imm = {{16{instr[15]}}, instr[15:0]};
		pc4 = ref_pc + 32'd4;
		ref_pc = pc4;
		case (op)
			6'h00: begin
				case (fn)
					6'h20: reg_update(instr[15:11], a + b);
					6'h22: reg_update(instr[15:11], a - b);
					6'h24: reg_update(instr[15:11], a & b);
					6'h25: reg_update(instr[15:11], a | b);
					6'h2a: reg_update(instr[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					6'h00: reg_update(instr[15:11], b << instr[10:6]);
					default: ;
				endcase
			end
			6'h08: reg_update(instr[20:16], a + imm);
			6'h23, 6'h2b: begin
				exp_data = 1'b1;
				exp_we = (op == 6'h2b);
				exp_adr = a + imm;
				exp_dat = b;
				exp_rt = instr[20:16];
			end
			6'h04: begin
				if (a == b) ref_pc = pc4 + {imm[29:0], 2'b00};
			end
			6'h02: ref_pc = {pc4[31:28], instr[25:0], 2'b00};
			default: ;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Bus watching
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			// Bus must idle once the first reset edge has passed
			if (in_reset) compare("reset_idle", 32'd0, {30'd0, wb_cyc, wb_stb});
			in_reset = 1'b1;
			prev_valid = 1'b0;
			ref_pc = `MIPS_RESET_PC;
			exp_data = 1'b0;
			retired = 0;
			halted = 1'b0;
		end else begin
			if (wb_stb && !wb_cyc) begin
				errors++;
				$display("stb was high without cyc");
			end
			if (prev_valid && prev_stb && !prev_ack) begin
				compare("adr_stable", prev_adr, wb_adr);
				compare("we_stable", {31'd0, prev_we}, {31'd0, wb_we});
				compare("dat_w_stable", prev_dat_w, wb_dat_w);
			end
			if (prev_valid && prev_ack && wb_cyc) begin
				errors++;
				$display("cyc stayed high in the cycle after ack");
			end

			if (wb_cyc && wb_stb && wb_ack && !halted) begin
				compare("sel", 32'hf, {28'd0, wb_sel});
				if (exp_data) begin
					exp_data = 1'b0;
					compare("data_we", {31'd0, exp_we}, {31'd0, wb_we});
					compare(exp_we ? "store_adr" : "load_adr", exp_adr, wb_adr);
					if (exp_we) begin
						compare("store_data", exp_dat, wb_dat_w);
						ref_mem[exp_adr] = exp_dat;
						if (exp_adr == `MIPS_HALT_ADDR) halted = 1'b1;
					end else begin
						compare("load_data", ref_read(exp_adr), wb_dat_r);
						reg_update(exp_rt, ref_read(exp_adr));
					end
				end else begin
					compare("fetch_we", 32'd0, {31'd0, wb_we});
					compare(retired == 0 ? "first_fetch" : "fetch_adr", ref_pc, wb_adr);
					retired++;
					ref_step(ref_read(ref_pc));
				end
			end

			prev_valid = 1'b1;
			prev_stb = wb_stb;
			prev_ack = wb_ack;
			prev_we = wb_we;
			prev_adr = wb_adr;
			prev_dat_w = wb_dat_w;
		end
	end

endmodule

// File: verification/mips_tb_image.svh
`ifndef MIPS_TB_IMAGE_SVH
`define MIPS_TB_IMAGE_SVH

localparam logic [31:0] LCG_SEED = 32'hd4f1_c7e1;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// Instruction encoders
function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
	return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// Operand words in the data region, one LCG step apart
function automatic logic [31:0] data_word(input int idx);
	logic [31:0] s;
	s = LCG_SEED;
	for (int k = 0; k <= idx; k++) begin
		s = lcg_next(s);
	end
	return s;
endfunction

// Directed program, r1 holds the data base after the first two words
function automatic logic [31:0] program_word(input int idx);
	case (idx)
		0:  return enc_i(6'h08, 5'd0, 5'd1, 16'h1001);
		1:  return enc_r(5'd0, 5'd1, 5'd1, 5'd16, 6'h00);
		2:  return enc_i(6'h23, 5'd1, 5'd2, 16'h0000);
		3:  return enc_i(6'h23, 5'd1, 5'd3, 16'h0004);
		4:  return enc_i(6'h2b, 5'd1, 5'd2, 16'h0100);
		5:  return enc_r(5'd2, 5'd3, 5'd4, 5'd0, 6'h20);
		6:  return enc_i(6'h2b, 5'd1, 5'd4, 16'h0104);
		7:  return enc_r(5'd2, 5'd3, 5'd5, 5'd0, 6'h22);
		8:  return enc_i(6'h2b, 5'd1, 5'd5, 16'h0108);
		9:  return enc_r(5'd2, 5'd3, 5'd6, 5'd0, 6'h24);
		10: return enc_i(6'h2b, 5'd1, 5'd6, 16'h010c);
		11: return enc_r(5'd2, 5'd3, 5'd7, 5'd0, 6'h25);
		12: return enc_i(6'h2b, 5'd1, 5'd7, 16'h0110);
		13: return enc_r(5'd2, 5'd3, 5'd8, 5'd0, 6'h2a);
		14: return enc_i(6'h2b, 5'd1, 5'd8, 16'h0114);
		15: return enc_r(5'd0, 5'd2, 5'd9, 5'd7, 6'h00);
		16: return enc_i(6'h2b, 5'd1, 5'd9, 16'h0118);
		17: return enc_i(6'h08, 5'd2, 5'd10, 16'hfed4);
		18: return enc_i(6'h2b, 5'd1, 5'd10, 16'h011c);
		// Write to r0 must not stick
		19: return enc_r(5'd2, 5'd3, 5'd0, 5'd0, 6'h20);
		20: return enc_i(6'h2b, 5'd1, 5'd0, 16'h0120);
		21: return enc_i(6'h04, 5'd2, 5'd2, 16'h0002);
		22: return enc_i(6'h2b, 5'd1, 5'd2, 16'h0124);
		23: return enc_i(6'h2b, 5'd1, 5'd3, 16'h0128);
		24: return enc_i(6'h04, 5'd2, 5'd3, 16'h0001);
		25: return enc_i(6'h08, 5'd0, 5'd11, 16'h0005);
		26: return enc_i(6'h2b, 5'd1, 5'd11, 16'h012c);
		27: return {6'h02, 26'h010_001d};
		28: return enc_i(6'h2b, 5'd1, 5'd2, 16'h0130);
		29: return enc_i(6'h23, 5'd1, 5'd12, 16'h0008);
		30: return enc_i(6'h2b, 5'd1, 5'd12, 16'h0134);
		31: return enc_i(6'h2b, 5'd1, 5'd4, 16'h0ffc);
		default: return 32'h0000_0000;
	endcase
endfunction

`endif

// File: verification/mips_core_tb.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_core_tb;

	`include "mips_tb_image.svh"

	localparam int PROG_WORDS = 40;
	localparam int DATA_WORDS = 8;
	// Words 22, 23 and 28 are skipped by the branch and the jump
	localparam int EXPECTED_RETIRED = 29;
	localparam int HALT_TIMEOUT = 4000;
	localparam int DRAIN_TIMEOUT = 16;
	localparam logic [31:0] DATA_BASE = 32'h1001_0000;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [3:0]  wb_sel;
	logic [31:0] wb_dat_r = '0;
	logic        wb_ack = 1'b0;

	logic [31:0] mem [logic [31:0]];
	logic [31:0] rng = LCG_SEED;
	logic [1:0]  waits = '0;
	logic        busy = 1'b0;
	logic        halt_seen = 1'b0;

	int          errors;
	int          checks;
	int          retired;
	logic        halted;
	int          extra_errors = 0;
	int          cycles;
	int          total;

	always #20 clk = ~clk;

	mips_core dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	mips_checker checker_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.errors   (errors),
		.checks   (checks),
		.retired  (retired),
		.halted   (halted)
	);

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (mem.exists(addr)) return mem[addr];
		return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	task automatic store_word(input logic [31:0] addr, input logic [31:0] word);
		mem[addr] = word;
		checker_i.preload(addr, word);
	endtask

	// Ack after 0 to 3 wait states, held for one cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			wb_ack = 1'b0;
			busy = 1'b0;
		end else if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy = 1'b1;
				rng = lcg_next(rng);
				waits = rng[17:16];
			end
			if (waits == 2'd0) begin
				busy = 1'b0;
				wb_ack = 1'b1;
				if (wb_we) begin
					mem[wb_adr] = wb_dat_w;
					if (wb_adr == `MIPS_HALT_ADDR) halt_seen = 1'b1;
				end else begin
					wb_dat_r = mem_read(wb_adr);
				end
			end else begin
				waits = waits - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			store_word(`MIPS_RESET_PC + 32'(4 * i), program_word(i));
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			store_word(DATA_BASE + 32'(4 * i), data_word(i));
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		cycles = 0;
		while (!halt_seen && cycles < HALT_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!halt_seen) begin
			$display("core never reached the halt store");
			extra_errors++;
		end else begin
			cycles = 0;
			while (!halted && cycles < DRAIN_TIMEOUT) begin
				@(posedge clk);
				cycles++;
			end
			if (!halted) begin
				$display("checker never saw the halt store on the bus");
				extra_errors++;
			end
			if (retired != EXPECTED_RETIRED) begin
				$display("Error retired_count: expected %0d, actual %0d",
					EXPECTED_RETIRED, retired);
				extra_errors++;
			end
		end

		total = errors + extra_errors;
		$display("Checks: %0d, errors: %0d, retired: %0d", checks, total, retired);
		if (total == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+logic
+incdir+verification
logic/mips_pkg.sv
logic/mips_ctrl_if.sv
logic/mips_control.sv
logic/mips_datapath.sv
logic/mips_bus_master.sv
logic/mips_core.sv
verification/mips_checker.sv
verification/mips_core_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module mips_core_tb -Mdir obj_dir -o mips_core_tb
	./obj_dir/mips_core_tb | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
